// ==== hdl/alu.sv ====
`default_nettype none

module alu import rv_pkg::*; (
    input  wire alu_op_e     alu_op,
    input  wire     [31:0]   a,
    input  wire     [31:0]   b,
    output logic    [31:0]   result
);
    logic signed_lt;
    logic unsigned_lt;

    assign signed_lt = $signed(a) < $signed(b);
    assign unsigned_lt = a < b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << b[4:0];
            ALU_SLT:  result = {31'b0, signed_lt};
            ALU_SLTU: result = {31'b0, unsigned_lt};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> b[4:0];
            ALU_SRA:  result = $signed(a) >>> b[4:0];
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            ALU_EQ:   result = {31'b0, a == b};
            ALU_NE:   result = {31'b0, a != b};
            ALU_LT:   result = {31'b0, signed_lt};
            ALU_GE:   result = {31'b0, !signed_lt};
            ALU_LTU:  result = {31'b0, unsigned_lt};
            default:  result = {31'b0, !unsigned_lt};
        endcase
    end
endmodule

`default_nettype wire

// ==== hdl/cpu_top.sv ====
`default_nettype none

module cpu_top (
    input  wire         clk,
    input  wire         rst,
    output wire  [31:0] address,
    output wire  [31:0] write_data,
    output wire  [3:0]  write_mask,
    output wire         write_enable,
    output wire         read_enable,
    input  wire  [31:0] read_data,
    input  wire         read_valid
);
    wire [31:0] pc;
    wire [31:0] instr;

    dmem_if dmem_i ();

    assign address = dmem_i.address;
    assign write_data = dmem_i.write_data;
    assign write_mask = dmem_i.write_mask;
    assign write_enable = dmem_i.write_enable;
    assign read_enable = dmem_i.read_enable;
    assign dmem_i.read_data = read_data;
    assign dmem_i.read_valid = read_valid;

    // ROM answers in the same cycle, fetch is always valid
    rv_core core_i (
        .clk(clk), .rst(rst), .pc(pc), .instruction(instr), .valid(1'b1),
        .dmem(dmem_i.core)
    );

    inst_rom rom_i (.pc(pc), .instr(instr));
endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
`default_nettype none

module decoder import rv_pkg::*; (
    input  wire  [31:0] instr,
    output ctrl_t       ctrl
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  arith_op = sub_sra ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    endfunction

    function automatic alu_op_e branch_op(input logic [2:0] f3);
        case (f3)
            3'b001:  branch_op = ALU_NE;
            3'b100:  branch_op = ALU_LT;
            3'b101:  branch_op = ALU_GE;
            3'b110:  branch_op = ALU_LTU;
            3'b111:  branch_op = ALU_GEU;
            default: branch_op = ALU_EQ;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    // funct7 bit 5, op-imm only honours it for shifts
    assign alt = instr[30] && (opcode == OP_REG || funct3 == 3'b101);

    always_comb begin
        ctrl = '0;
        ctrl.src_a = SRC_RS1;
        case (opcode)
            OP_REG: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op = arith_op(funct3, alt);
            end
            OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src = 1'b1;
                ctrl.alu_op = arith_op(funct3, alt);
            end
            OP_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.result_src = RES_MEM;
                ctrl.alu_src = 1'b1;
            end
            OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src = 1'b1;
                ctrl.imm_fmt = IMM_S;
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = branch_op(funct3);
                ctrl.imm_fmt = IMM_B;
            end
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump = 1'b1;
                ctrl.result_src = RES_PC4;
                ctrl.imm_fmt = IMM_J;
            end
            OP_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump = 1'b1;
                ctrl.result_src = RES_PC4;
                ctrl.pc_alu_src = 1'b1;
            end
            OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.result_src = RES_IMM;
                ctrl.alu_src = 1'b1;
                ctrl.imm_fmt = IMM_U;
                ctrl.src_a = SRC_ZERO;
            end
            OP_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src = 1'b1;
                ctrl.imm_fmt = IMM_U;
                ctrl.src_a = SRC_PC;
            end
            default: ctrl = '0;
        endcase
    end
endmodule

`default_nettype wire

// ==== hdl/dmem_if.sv ====
`default_nettype none

interface dmem_if;
    logic [31:0] address;
    logic [31:0] write_data;
    logic [3:0]  write_mask;
    logic        write_enable;
    // Held until read_valid
    logic        read_enable;
    logic [31:0] read_data;
    logic        read_valid;

    modport core (
        output address, write_data, write_mask, write_enable, read_enable,
        input  read_data, read_valid
    );

    modport mem (
        input  address, write_data, write_mask, write_enable, read_enable,
        output read_data, read_valid
    );
endinterface

`default_nettype wire

// ==== hdl/hazard_unit.sv ====
`default_nettype none

module hazard_unit import rv_pkg::*; (
    input  wire  [4:0] rs1_d,
    input  wire  [4:0] rs2_d,
    input  wire  [4:0] rs1_e,
    input  wire  [4:0] rs2_e,
    input  wire  [4:0] rd_e,
    input  wire  [4:0] rd_m,
    input  wire  [4:0] rd_w,
    input  wire        load_e,
    input  wire        reg_write_m,
    input  wire        reg_write_w,
    input  wire        pc_src_e,
    input  wire        read_enable,
    input  wire        read_valid,
    output logic       stall_f,
    output logic       stall_d,
    output logic       stall_read,
    output logic       flush_d,
    output logic       flush_e,
    output fwd_e       forward_a,
    output fwd_e       forward_b
);
    logic load_use;

    function automatic fwd_e fwd_sel(input logic [4:0] rs);
        if (rs != 5'd0 && rs == rd_m && reg_write_m) begin
            fwd_sel = FWD_MEM;
        end else if (rs != 5'd0 && rs == rd_w && reg_write_w) begin
            fwd_sel = FWD_WB;
        end else begin
            fwd_sel = FWD_NONE;
        end
    endfunction

    always_comb begin
        forward_a = fwd_sel(rs1_e);
        forward_b = fwd_sel(rs2_e);
    end

    assign load_use = load_e && rd_e != 5'd0 && (rd_e == rs1_d || rd_e == rs2_d);
    assign stall_f = load_use;
    assign stall_d = load_use;
    assign stall_read = read_enable && !read_valid;

    // Execute is frozen during a memory wait, so nothing is flushed then
    assign flush_d = pc_src_e && !stall_read;
    assign flush_e = (load_use || pc_src_e) && !stall_read;
endmodule

`default_nettype wire

// ==== hdl/inst_rom.sv ====
`default_nettype none

module inst_rom import rv_pkg::*; (
    input  wire  [31:0] pc,
    output logic [31:0] instr
);
    logic [31:0] rom [ROM_WORDS];
    logic [31:0] offset;

    initial begin
        $readmemh("tests/program.hex", rom);
    end

    // Word index relative to the reset vector
    assign offset = pc - RESET_PC;
    assign instr = rom[offset[$clog2(ROM_WORDS)+1:2]];
endmodule

`default_nettype wire

// ==== hdl/pipe_reg.sv ====
`default_nettype none

module pipe_reg #(
    parameter type T = logic
) (
    input  wire clk,
    input  wire rst,
    input  wire stall,
    input  wire flush,
    input  wire T d,
    output T      q
);
    // Flush beats stall, an all-zero payload is a bubble
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end
endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`default_nettype none

module regfile (
    input  wire         clk,
    input  wire         rst,
    input  wire  [4:0]  rs1,
    input  wire  [4:0]  rs2,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    input  wire  [4:0]  rd,
    input  wire  [31:0] wd,
    input  wire         we
);
    logic [31:0] regs [32];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

    // Write-through, decode sees the value retiring this cycle
    assign rd1 = (we && rd != 5'd0 && rd == rs1) ? wd : regs[rs1];
    assign rd2 = (we && rd != 5'd0 && rd == rs2) ? wd : regs[rs2];
endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
`default_nettype none

module rv_core import rv_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    output logic [31:0] pc,
    input  wire  [31:0] instruction,
    input  wire         valid,
    dmem_if.core        dmem
);
    if_id_t      if_d, if_q;
    id_ex_t      id_d, id_q, id_hold, ex_in;
    ex_mem_t     ex_d, ex_q;
    mem_wb_t     mem_d, wb_q;
    ctrl_t       ctrl_d;
    logic [31:0] instr_d, imm_d, rd1_d, rd2_d;
    logic [31:0] pc_plus_4, pc_base, pc_target;
    logic [31:0] rs1_val, rs2_val, src_a, src_b, alu_result;
    logic [31:0] fwd_m, load_w, result_w;
    logic        pc_src, stall_f, stall_d, stall_read, flush_d, flush_e;
    fwd_e        forward_a, forward_b;

    assign pc_plus_4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (valid && !stall_f && !stall_read) begin
            pc <= pc_src ? pc_target : pc_plus_4;
        end
    end

    assign if_d = '{instr: instruction, pc: pc, pc_plus_4: pc_plus_4};

    pipe_reg #(.T(if_id_t)) if_id_i (
        .clk(clk), .rst(rst), .stall(stall_d || stall_read || !valid),
        .flush(flush_d), .d(if_d), .q(if_q)
    );

    assign instr_d = if_q.instr;

    decoder decoder_i (.instr(instr_d), .ctrl(ctrl_d));

    regfile regfile_i (
        .clk(clk), .rst(rst), .rs1(instr_d[19:15]), .rs2(instr_d[24:20]),
        .rd1(rd1_d), .rd2(rd2_d), .rd(wb_q.rd), .wd(result_w), .we(wb_q.reg_write)
    );

    always_comb begin
        case (ctrl_d.imm_fmt)
            IMM_S:   imm_d = {{20{instr_d[31]}}, instr_d[31:25], instr_d[11:7]};
            IMM_B:   imm_d = {{20{instr_d[31]}}, instr_d[7], instr_d[30:25],
                              instr_d[11:8], 1'b0};
            IMM_J:   imm_d = {{12{instr_d[31]}}, instr_d[19:12], instr_d[20],
                              instr_d[30:21], 1'b0};
            IMM_U:   imm_d = {instr_d[31:12], 12'b0};
            default: imm_d = {{20{instr_d[31]}}, instr_d[31:20]};
        endcase
    end

    assign id_d = '{ctrl: ctrl_d, rd1: rd1_d, rd2: rd2_d, pc: if_q.pc, imm: imm_d,
                    pc_plus_4: if_q.pc_plus_4, rs1: instr_d[19:15], rs2: instr_d[24:20],
                    rd: instr_d[11:7], funct3: instr_d[14:12]};

    // While a load waits, execute reloads itself with forwarded operands
    // so a writeback that retires meanwhile is not lost
    always_comb begin
        id_hold = id_q;
        id_hold.rd1 = rs1_val;
        id_hold.rd2 = rs2_val;
    end

    assign ex_in = stall_read ? id_hold : id_d;

    pipe_reg #(.T(id_ex_t)) id_ex_i (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(flush_e), .d(ex_in), .q(id_q)
    );

    always_comb begin
        case (forward_a)
            FWD_MEM: rs1_val = fwd_m;
            FWD_WB:  rs1_val = result_w;
            default: rs1_val = id_q.rd1;
        endcase
        case (forward_b)
            FWD_MEM: rs2_val = fwd_m;
            FWD_WB:  rs2_val = result_w;
            default: rs2_val = id_q.rd2;
        endcase
        case (id_q.ctrl.src_a)
            SRC_RS1: src_a = rs1_val;
            SRC_PC:  src_a = id_q.pc;
            default: src_a = '0;
        endcase
    end

    assign src_b = id_q.ctrl.alu_src ? id_q.imm : rs2_val;

    alu alu_i (.alu_op(id_q.ctrl.alu_op), .a(src_a), .b(src_b), .result(alu_result));

    assign pc_base = id_q.ctrl.pc_alu_src ? rs1_val : id_q.pc;
    assign pc_target = (pc_base + id_q.imm) & ~32'd1;
    assign pc_src = id_q.ctrl.jump || (id_q.ctrl.branch && alu_result[0]);

    assign ex_d = '{reg_write: id_q.ctrl.reg_write, result_src: id_q.ctrl.result_src,
                    mem_write: id_q.ctrl.mem_write, alu_result: alu_result,
                    write_data: rs2_val, pc_plus_4: id_q.pc_plus_4, imm: id_q.imm,
                    rd: id_q.rd, funct3: id_q.funct3};

    pipe_reg #(.T(ex_mem_t)) ex_mem_i (
        .clk(clk), .rst(rst), .stall(stall_read), .flush(1'b0), .d(ex_d), .q(ex_q)
    );

    assign dmem.address = ex_q.alu_result;
    assign dmem.write_data = ex_q.write_data;
    assign dmem.write_enable = ex_q.mem_write;
    assign dmem.read_enable = ex_q.result_src == RES_MEM;

    always_comb begin
        case (ex_q.funct3[1:0])
            2'b00:   dmem.write_mask = 4'b0001;
            2'b01:   dmem.write_mask = 4'b0011;
            default: dmem.write_mask = 4'b1111;
        endcase
        // Loads never forward from here, load-use stalls first
        case (ex_q.result_src)
            RES_PC4: fwd_m = ex_q.pc_plus_4;
            RES_IMM: fwd_m = ex_q.imm;
            default: fwd_m = ex_q.alu_result;
        endcase
    end

    assign mem_d = '{reg_write: ex_q.reg_write, result_src: ex_q.result_src,
                     alu_result: ex_q.alu_result, read_data: dmem.read_data,
                     pc_plus_4: ex_q.pc_plus_4, imm: ex_q.imm, rd: ex_q.rd,
                     funct3: ex_q.funct3};

    // Bubble into writeback for every wait cycle
    pipe_reg #(.T(mem_wb_t)) mem_wb_i (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(stall_read), .d(mem_d), .q(wb_q)
    );

    always_comb begin
        case (wb_q.funct3)
            3'b000:  load_w = {{24{wb_q.read_data[7]}}, wb_q.read_data[7:0]};
            3'b001:  load_w = {{16{wb_q.read_data[15]}}, wb_q.read_data[15:0]};
            3'b100:  load_w = {24'b0, wb_q.read_data[7:0]};
            3'b101:  load_w = {16'b0, wb_q.read_data[15:0]};
            default: load_w = wb_q.read_data;
        endcase
        case (wb_q.result_src)
            RES_MEM: result_w = load_w;
            RES_PC4: result_w = wb_q.pc_plus_4;
            RES_IMM: result_w = wb_q.imm;
            default: result_w = wb_q.alu_result;
        endcase
    end

    hazard_unit hazard_i (
        .rs1_d(instr_d[19:15]), .rs2_d(instr_d[24:20]),
        .rs1_e(id_q.rs1), .rs2_e(id_q.rs2), .rd_e(id_q.rd), .rd_m(ex_q.rd), .rd_w(wb_q.rd),
        .load_e(id_q.ctrl.result_src == RES_MEM),
        .reg_write_m(ex_q.reg_write), .reg_write_w(wb_q.reg_write),
        .pc_src_e(pc_src), .read_enable(dmem.read_enable), .read_valid(dmem.read_valid),
        .stall_f(stall_f), .stall_d(stall_d), .stall_read(stall_read),
        .flush_d(flush_d), .flush_e(flush_e), .forward_a(forward_a), .forward_b(forward_b)
    );
endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam logic [31:0] RESET_PC = 32'h8000_0000;
    localparam int ROM_WORDS = 64;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND,
        // Branch compares, outcome in bit 0
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
    } alu_op_e;

    typedef enum logic [2:0] {
        RES_ALU = 3'b000,
        RES_MEM = 3'b001,
        RES_PC4 = 3'b010,
        RES_IMM = 3'b011
    } result_src_e;

    typedef enum logic [1:0] {SRC_ZERO, SRC_RS1, SRC_PC} src_a_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U} imm_fmt_e;

    typedef enum logic [1:0] {FWD_NONE, FWD_WB, FWD_MEM} fwd_e;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        logic        mem_write;
        logic        jump;
        logic        branch;
        alu_op_e     alu_op;
        logic        alu_src;
        imm_fmt_e    imm_fmt;
        // Register base for the target adder (jalr)
        logic        pc_alu_src;
        src_a_e      src_a;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] pc_plus_4;
    } if_id_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] pc_plus_4;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  funct3;
    } id_ex_t;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        logic        mem_write;
        logic [31:0] alu_result;
        logic [31:0] write_data;
        logic [31:0] pc_plus_4;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [2:0]  funct3;
    } ex_mem_t;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        logic [31:0] alu_result;
        logic [31:0] read_data;
        logic [31:0] pc_plus_4;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [2:0]  funct3;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_cpu_top -f sim.f -o tb_cpu_top \
    && ./obj_dir/tb_cpu_top 2>&1 | tee sim.log \
    && ! grep -q "TESTBENCH FAILED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }

// ==== sim.f ====
hdl/rv_pkg.sv
hdl/dmem_if.sv
hdl/pipe_reg.sv
hdl/decoder.sv
hdl/alu.sv
hdl/regfile.sv
hdl/hazard_unit.sv
hdl/inst_rom.sv
hdl/rv_core.sv
hdl/cpu_top.sv
tests/tb_cpu_top.sv

// ==== tests/program.hex ====
// One RV32I instruction word per line, the first at the reset PC
12300093  // addi x1, x0, 0x123
04508113  // addi x2, x1, 0x45
001101b3  // add  x3, x2, x1
40218233  // sub  x4, x3, x2
003242b3  // xor  x5, x4, x3
00429313  // slli x6, x5, 4
10602023  // sw   x6, 0x100(x0)
123483b7  // lui  x7, 0x12348
28138393  // addi x7, x7, 0x281
10702223  // sw   x7, 0x104(x0)
10400403  // lb   x8, 0x104(x0)
10802423  // sw   x8, 0x108(x0)
10401483  // lh   x9, 0x104(x0)
10404503  // lbu  x10, 0x104(x0)
10405583  // lhu  x11, 0x104(x0)
10402603  // lw   x12, 0x104(x0)
10902623  // sw   x9, 0x10c(x0)
10a02823  // sw   x10, 0x110(x0)
10b02a23  // sw   x11, 0x114(x0)
10c02c23  // sw   x12, 0x118(x0)
10002683  // lw   x13, 0x100(x0)
01168713  // addi x14, x13, 0x11
10e02e23  // sw   x14, 0x11c(x0)
00120463  // beq  x4, x1, +8
1e002823  // sw   x0, 0x1f0(x0)  shadow
00121463  // bne  x4, x1, +8
12502023  // sw   x5, 0x120(x0)
008007ef  // jal  x15, +8
1e002823  // sw   x0, 0x1f0(x0)  shadow
12f02223  // sw   x15, 0x124(x0)
01078867  // jalr x16, 16(x15)
1e002823  // sw   x0, 0x1f0(x0)  shadow
13002423  // sw   x16, 0x128(x0)
12700623  // sb   x7, 0x12c(x0)
12701823  // sh   x7, 0x130(x0)
0000006f  // jal  x0, 0

// ==== tests/tb_cpu_top.sv ====
`default_nettype none

module tb_cpu_top import rv_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 8;
    // About 60 instructions, each with up to four stall cycles, plus margin
    localparam int INSTR_BUDGET = 60;
    localparam int MAX_STALLS = 4;
    localparam int WATCHDOG_CYCLES = INSTR_BUDGET * (1 + MAX_STALLS) + 100;
    localparam int STORE_TOTAL = 13;
    // Positions of the jumps in program.hex
    localparam int JAL_INDEX = 27;
    localparam int JALR_INDEX = 30;
    localparam logic [31:0] SHADOW_ADDR = 32'h1f0;

    // Program constants and the arithmetic chain built from them
    localparam logic [31:0] X1 = 32'h123;
    localparam logic [31:0] X2 = X1 + 32'h45;
    localparam logic [31:0] X3 = X2 + X1;
    localparam logic [31:0] X4 = X3 - X2;
    localparam logic [31:0] X5 = X4 ^ X3;
    localparam logic [31:0] X6 = X5 << 4;
    localparam logic [31:0] X7 = 32'h1234_8000 + 32'h281;

    logic        clk;
    logic        rst;
    logic [31:0] read_data;
    logic        read_valid;
    wire  [31:0] address;
    wire  [31:0] write_data;
    wire  [3:0]  write_mask;
    wire         write_enable;
    wire         read_enable;

    logic [31:0] mem [256];
    logic [31:0] log_addr [$];
    logic [31:0] log_data [$];
    logic [3:0]  log_mask [$];
    int          store_count;
    int          errors;
    logic        read_busy;
    int unsigned read_wait;

    cpu_top dut_i (
        .clk(clk), .rst(rst), .address(address), .write_data(write_data),
        .write_mask(write_mask), .write_enable(write_enable), .read_enable(read_enable),
        .read_data(read_data), .read_valid(read_valid)
    );

    always #20 clk = ~clk;

    // New random read latency of 0 to 3 cycles for every load
    initial begin
        void'($urandom(32'h53cf_c004));
        forever begin
            @(posedge clk);
            #2;
            if (read_valid) begin
                read_busy = 1'b0;
            end
            if (read_enable && !read_busy) begin
                read_busy = 1'b1;
                read_wait = $urandom % 4;
            end
            if (read_busy && read_wait == 0) begin
                read_valid = 1'b1;
                read_data = mem[address[9:2]];
            end else begin
                if (read_busy) begin
                    read_wait--;
                end
                read_valid = 1'b0;
                read_data = $urandom;
            end
        end
    end

    // Stores are taken mid-cycle where the bus is stable
    always @(negedge clk) begin
        if (write_enable) begin
            for (int b = 0; b < 4; b++) begin
                if (write_mask[b]) begin
                    mem[address[9:2]][8*b +: 8] = write_data[8*b +: 8];
                end
            end
            log_addr.push_back(address);
            log_data.push_back(write_data);
            log_mask.push_back(write_mask);
            store_count++;
        end
    end

    task automatic check_bus_idle(input string when);
        assert (!read_enable && !write_enable) else begin
            errors++;
            $display("CHECK FAILED at %0t: bus strobes active %s", $time, when);
        end
    endtask

    task automatic expect_store(input int idx, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] mask,
                                input string what);
        wait (store_count > idx);
        assert (log_addr[idx] == addr && log_data[idx] == data && log_mask[idx] == mask)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: %s, store %0d got %h/%h/%b, expected %h/%h/%b",
                     $time, what, idx, log_addr[idx], log_data[idx], log_mask[idx],
                     addr, data, mask);
        end
    endtask

    task automatic check_reset();
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #2;
            check_bus_idle("during reset");
        end
        rst = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bus_idle("in the first cycle after reset");
    endtask

    task automatic test_forwarding();
        expect_store(0, 32'h100, X6, 4'b1111, "addi/add/sub/xor/slli chain");
    endtask

    task automatic test_loads();
        logic [31:0] word;
        expect_store(1, 32'h104, X7, 4'b1111, "sw of the load source");
        word = X7;
        expect_store(2, 32'h108, {{24{word[7]}}, word[7:0]}, 4'b1111, "lb");
        expect_store(3, 32'h10c, {{16{word[15]}}, word[15:0]}, 4'b1111, "lh");
        expect_store(4, 32'h110, {24'b0, word[7:0]}, 4'b1111, "lbu");
        expect_store(5, 32'h114, {16'b0, word[15:0]}, 4'b1111, "lhu");
        expect_store(6, 32'h118, word, 4'b1111, "lw");
    endtask

    task automatic test_load_use();
        expect_store(7, 32'h11c, X6 + 32'h11, 4'b1111, "addi on a just-loaded register");
    endtask

    task automatic test_control_flow();
        expect_store(8, 32'h120, X5, 4'b1111, "store after taken beq and not-taken bne");
        expect_store(9, 32'h124, RESET_PC + 4 * (JAL_INDEX + 1), 4'b1111, "jal link");
        expect_store(10, 32'h128, RESET_PC + 4 * (JALR_INDEX + 1), 4'b1111, "jalr link");
    endtask

    task automatic test_store_masks();
        expect_store(11, 32'h12c, X7, 4'b0001, "sb");
        expect_store(12, 32'h130, X7, 4'b0011, "sh");
    endtask

    // The program parks in a self-jump, so the log must stay quiet
    task automatic check_no_extra_stores();
        repeat (20) @(posedge clk);
        assert (store_count == STORE_TOTAL) else begin
            errors++;
            $display("CHECK FAILED at %0t: %0d stores seen, expected %0d",
                     $time, store_count, STORE_TOTAL);
        end
        foreach (log_addr[i]) begin
            assert (log_addr[i] != SHADOW_ADDR) else begin
                errors++;
                $display("Store %0d from a flushed branch shadow reached the bus", i);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        read_data = '0;
        read_valid = 1'b0;
        read_busy = 1'b0;
        read_wait = 0;
        store_count = 0;
        errors = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5a5a_0000 ^ (i * 32'h0101_0101);
        end
        check_reset();
        test_forwarding();
        test_loads();
        test_load_use();
        test_control_flow();
        test_store_masks();
        check_no_extra_stores();
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the program never reached its final store",
                 WATCHDOG_CYCLES);
        $display("Run stopped with %0d errors and %0d stores", errors, store_count);
        $display("TESTBENCH FAILED");
        $finish;
    end
endmodule

`default_nettype wire
